//--- lom_cfg_pkg.sv
package lom_cfg_pkg;

    // operand and result words
    localparam int OP_W  = 8;
    localparam int RES_W = 2 * OP_W;

    // buffer capacity in operand pairs
    localparam int MAX_PAIRS = 8;

    typedef logic [OP_W-1:0]  op_t;
    typedef logic [RES_W-1:0] res_t;

    // word address of the operand buffer, one extra bit so it can run past the last pair
    localparam int ADDR_W = $clog2(2 * MAX_PAIRS) + 1;

    // holds k1+k2, at most 2*(OP_W-1)
    localparam int SH_W = $clog2(2 * (OP_W - 1) + 1);

endpackage

//--- lom_regs_pkg.sv
package lom_regs_pkg;

    localparam int AXI_AW = 8;

    // control and status
    localparam logic [AXI_AW-1:0] REG_CTRL   = 8'h00;
    localparam logic [AXI_AW-1:0] REG_STATUS = 8'h04;
    localparam logic [AXI_AW-1:0] REG_COUNT  = 8'h08;

    // operand words, even index first operand
    localparam logic [AXI_AW-1:0] OPND_BASE = 8'h40;
    // results, one word per pair
    localparam logic [AXI_AW-1:0] RES_BASE  = 8'h80;

    // bit positions
    localparam int CTRL_START  = 0;
    localparam int STATUS_DONE = 0;
    localparam int STATUS_BUSY = 1;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- lom_ctrl_if.sv
interface lom_ctrl_if;

    // strobes from the controller
    logic init_load;
    logic init_sh;
    logic en_cnt_load;
    logic load_shift1;
    logic load_shift2;
    logic en_shift1;
    logic en_shift2;
    logic ld_cnt_sh;
    logic en_cnt_sh;
    logic load_result;
    logic shift_result;
    logic wr_ram;

    // status back to the controller
    logic lsb_cnt;
    logic end_shift1;
    logic end_shift2;
    logic co_cnt_sh;
    logic co_cnt_load;

    modport ctrl (
        output init_load, init_sh, en_cnt_load, load_shift1, load_shift2,
        output en_shift1, en_shift2, ld_cnt_sh, en_cnt_sh, load_result,
        output shift_result, wr_ram,
        input  lsb_cnt, end_shift1, end_shift2, co_cnt_sh, co_cnt_load
    );

    modport cnt (
        input  init_load, init_sh, en_cnt_load, en_shift1, en_shift2,
        input  ld_cnt_sh, en_cnt_sh, shift_result,
        output lsb_cnt, co_cnt_sh, co_cnt_load
    );

    modport dp (
        input  load_shift1, load_shift2, en_shift1, en_shift2, load_result, shift_result,
        output end_shift1, end_shift2
    );

endinterface

//--- lom_axil_regs.sv
module lom_axil_regs #(
    parameter int MAX_PAIRS = lom_cfg_pkg::MAX_PAIRS,
    parameter int HA_W      = $clog2(2 * MAX_PAIRS) + 1,
    parameter int CW        = $clog2(MAX_PAIRS + 1)
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [lom_regs_pkg::AXI_AW-1:0] s_awaddr,
    input  logic                             s_awvalid,
    output logic                             s_awready,
    input  logic [31:0]                      s_wdata,
    input  logic [3:0]                       s_wstrb,
    input  logic                             s_wvalid,
    output logic                             s_wready,
    output logic [1:0]                       s_bresp,
    output logic                             s_bvalid,
    input  logic                             s_bready,
    input  logic [lom_regs_pkg::AXI_AW-1:0] s_araddr,
    input  logic                             s_arvalid,
    output logic                             s_arready,
    output logic [31:0]                      s_rdata,
    output logic [1:0]                       s_rresp,
    output logic                             s_rvalid,
    input  logic                             s_rready,
    output logic                             start,
    output logic [CW-1:0]                    pair_count,
    output logic                             host_we,
    output logic [HA_W-1:0]                  host_addr,
    output lom_cfg_pkg::op_t                 host_wdata,
    input  lom_cfg_pkg::res_t                host_rdata,
    input  logic                             done
);
    import lom_regs_pkg::*;

    localparam logic [AXI_AW-1:0] OPND_END = OPND_BASE + AXI_AW'(8 * MAX_PAIRS);
    localparam logic [AXI_AW-1:0] RES_END  = RES_BASE + AXI_AW'(4 * MAX_PAIRS);

    logic aw_hs, ar_hs, rd_pend, busy, done_q;
    logic w_ctrl, w_status, w_count, w_opnd, w_err, w_lane;
    logic r_opnd, r_res, r_known;

    // buffer word address, top bit picks the result array
    function automatic logic [HA_W-1:0] buf_addr(input logic [AXI_AW-1:0] a);
        logic [AXI_AW-1:0] off;
        if (a >= RES_BASE) begin
            off = (a - RES_BASE) >> 2;
            return {1'b1, off[HA_W-2:0]};
        end
        off = (a - OPND_BASE) >> 2;
        return {1'b0, off[HA_W-2:0]};
    endfunction

    assign aw_hs     = s_awvalid && s_wvalid && !s_bvalid;
    assign s_awready = aw_hs;
    assign s_wready  = aw_hs;
    // a read never shares the host port with a write in the same cycle
    assign s_arready = !s_rvalid && !rd_pend && !aw_hs;
    assign ar_hs     = s_arvalid && s_arready;

    assign w_ctrl   = s_awaddr == REG_CTRL;
    assign w_status = s_awaddr == REG_STATUS;
    assign w_count  = s_awaddr == REG_COUNT;
    assign w_opnd   = s_awaddr >= OPND_BASE && s_awaddr < OPND_END;
    assign w_lane   = s_wstrb[0];
    assign w_err    = !(w_ctrl || w_status || w_count || w_opnd)
                    || (busy && (w_opnd || w_count))
                    || (w_count && (s_wdata == 0 || s_wdata > MAX_PAIRS));

    assign r_opnd  = s_araddr >= OPND_BASE && s_araddr < OPND_END;
    assign r_res   = s_araddr >= RES_BASE && s_araddr < RES_END;
    assign r_known = s_araddr == REG_CTRL || s_araddr == REG_STATUS
                  || s_araddr == REG_COUNT;

    assign host_we    = aw_hs && w_opnd && !w_err && w_lane;
    assign host_addr  = aw_hs ? buf_addr(s_awaddr) : buf_addr(s_araddr);
    assign host_wdata = s_wdata[$bits(host_wdata)-1:0];

    // write channel, control and count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_bvalid   <= 1'b0;
            start      <= 1'b0;
            busy       <= 1'b0;
            pair_count <= CW'(1);
        end else begin
            start <= aw_hs && w_ctrl && w_lane && s_wdata[CTRL_START] && !busy;
            if (start) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            if (aw_hs && w_count && !w_err && w_lane) begin
                pair_count <= s_wdata[CW-1:0];
            end
            if (aw_hs) begin
                s_bvalid <= 1'b1;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            s_bresp <= w_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // read channel, buffer reads wait one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_rvalid <= 1'b0;
            rd_pend  <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            if (done) begin
                done_q <= 1'b1;
            end else if (ar_hs && s_araddr == REG_STATUS) begin
                done_q <= 1'b0;
            end
            if (ar_hs && (r_opnd || r_res)) begin
                rd_pend <= 1'b1;
            end else if (ar_hs || rd_pend) begin
                rd_pend  <= 1'b0;
                s_rvalid <= 1'b1;
            end else if (s_rready) begin
                s_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend) begin
            s_rdata <= 32'(host_rdata);
            s_rresp <= RESP_OKAY;
        end else if (ar_hs) begin
            s_rresp <= (r_known || r_opnd || r_res) ? RESP_OKAY : RESP_SLVERR;
            s_rdata <= '0;
            if (s_araddr == REG_STATUS) begin
                s_rdata[STATUS_DONE] <= done_q;
                s_rdata[STATUS_BUSY] <= busy;
            end else if (s_araddr == REG_COUNT) begin
                s_rdata <= 32'(pair_count);
            end
        end
    end

endmodule

//--- lom_buffers.sv
module lom_buffers #(
    parameter int MAX_PAIRS = lom_cfg_pkg::MAX_PAIRS,
    parameter int HA_W      = $clog2(2 * MAX_PAIRS) + 1,
    parameter int RI_W      = $clog2(MAX_PAIRS)
) (
    input  logic              clk,
    input  logic              we,
    input  logic [HA_W-1:0]   addr,
    input  lom_cfg_pkg::op_t  wdata,
    output lom_cfg_pkg::res_t rdata,
    input  logic [HA_W-2:0]   eng_addr,
    output lom_cfg_pkg::op_t  eng_opnd,
    input  logic              res_we,
    input  logic [RI_W-1:0]   res_idx,
    input  lom_cfg_pkg::res_t res_data
);
    import lom_cfg_pkg::*;

    op_t  opnd_mem [2*MAX_PAIRS];
    res_t res_mem  [MAX_PAIRS];

    always_ff @(posedge clk) begin
        if (we) begin
            opnd_mem[addr[HA_W-2:0]] <= wdata;
        end
        if (res_we) begin
            res_mem[res_idx] <= res_data;
        end
        // host reads either array
        rdata    <= addr[HA_W-1] ? res_mem[addr[RI_W-1:0]] : RES_W'(opnd_mem[addr[HA_W-2:0]]);
        eng_opnd <= opnd_mem[eng_addr];
    end

endmodule

//--- lom_controller.sv
module lom_controller (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    lom_ctrl_if.ctrl        ctl,
    output logic            done
);

    localparam logic [3:0] IDLE      = 4'd0;
    localparam logic [3:0] START     = 4'd1;
    localparam logic [3:0] LOAD1     = 4'd2;
    localparam logic [3:0] LOAD2     = 4'd3;
    localparam logic [3:0] LOAD3     = 4'd4;
    localparam logic [3:0] FIND_BITS = 4'd5;
    localparam logic [3:0] SHIFT_RES = 4'd6;
    localparam logic [3:0] WR        = 4'd7;
    localparam logic [3:0] DONE      = 4'd8;

    logic [3:0] state, next_state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = IDLE;
        case (state)
            IDLE:      next_state = start ? START : IDLE;
            START:     next_state = LOAD1;
            LOAD1:     next_state = LOAD2;
            LOAD2:     next_state = LOAD3;
            LOAD3:     next_state = FIND_BITS;
            // stay until both operands are normalized
            FIND_BITS: next_state = (ctl.end_shift1 || ctl.end_shift2) ? FIND_BITS : SHIFT_RES;
            SHIFT_RES: next_state = ctl.co_cnt_sh ? WR : SHIFT_RES;
            WR:        next_state = ctl.co_cnt_load ? DONE : LOAD1;
            DONE:      next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    always_comb begin
        ctl.init_load    = 1'b0;
        ctl.init_sh      = 1'b0;
        ctl.en_cnt_load  = 1'b0;
        ctl.load_shift1  = 1'b0;
        ctl.load_shift2  = 1'b0;
        ctl.en_shift1    = 1'b0;
        ctl.en_shift2    = 1'b0;
        ctl.ld_cnt_sh    = 1'b0;
        ctl.en_cnt_sh    = 1'b0;
        ctl.load_result  = 1'b0;
        ctl.shift_result = 1'b0;
        ctl.wr_ram       = 1'b0;
        done             = 1'b0;
        case (state)
            IDLE: begin
                ctl.init_load = 1'b1;
                ctl.init_sh   = 1'b1;
            end
            LOAD1: begin
                ctl.en_cnt_load = 1'b1;
            end
            LOAD2: begin
                // odd address means the even word is on the read port
                ctl.load_shift1 = ctl.lsb_cnt;
                ctl.load_shift2 = !ctl.lsb_cnt;
                ctl.en_cnt_load = 1'b1;
            end
            LOAD3: begin
                ctl.load_shift1 = ctl.lsb_cnt;
                ctl.load_shift2 = !ctl.lsb_cnt;
            end
            FIND_BITS: begin
                ctl.en_shift1   = ctl.end_shift1;
                ctl.en_shift2   = ctl.end_shift2;
                ctl.load_result = 1'b1;
                ctl.ld_cnt_sh   = 1'b1;
            end
            SHIFT_RES: begin
                ctl.en_cnt_sh    = 1'b1;
                ctl.shift_result = !ctl.co_cnt_sh;
            end
            WR: begin
                ctl.init_sh = 1'b1;
                ctl.wr_ram  = 1'b1;
            end
            DONE: begin
                done = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- lom_counters.sv
module lom_counters #(
    parameter int OP_W      = lom_cfg_pkg::OP_W,
    parameter int MAX_PAIRS = lom_cfg_pkg::MAX_PAIRS,
    parameter int AW        = $clog2(2 * MAX_PAIRS) + 1,
    parameter int CW        = $clog2(MAX_PAIRS + 1),
    parameter int RI_W      = $clog2(MAX_PAIRS)
) (
    input  logic            clk,
    input  logic            rst,
    lom_ctrl_if.cnt         ctl,
    input  logic [CW-1:0]   pair_count,
    output logic [AW-2:0]   eng_addr,
    output logic [RI_W-1:0] res_idx
);

    localparam int SH_W = $clog2(2 * (OP_W - 1) + 1);
    localparam logic [SH_W-1:0] SH_MAX = SH_W'(2 * (OP_W - 1));

    logic [AW-1:0]   load_addr;
    logic [AW-1:0]   pair_idx;
    logic [SH_W-1:0] n1, n2, res_cnt;

    // both words of the pair are fetched, the address points one past them
    assign pair_idx        = (load_addr - 1'b1) >> 1;
    assign eng_addr        = load_addr[AW-2:0];
    assign res_idx         = pair_idx[RI_W-1:0];
    assign ctl.lsb_cnt     = load_addr[0];
    assign ctl.co_cnt_load = pair_idx == AW'(pair_count - 1'b1);
    assign ctl.co_cnt_sh   = res_cnt == '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_addr <= '0;
            n1        <= '0;
            n2        <= '0;
            res_cnt   <= '0;
        end else begin
            if (ctl.init_load) begin
                load_addr <= '0;
            end else if (ctl.en_cnt_load) begin
                load_addr <= load_addr + 1'b1;
            end
            if (ctl.init_sh) begin
                n1 <= '0;
                n2 <= '0;
            end else begin
                if (ctl.en_shift1) n1 <= n1 + 1'b1;
                if (ctl.en_shift2) n2 <= n2 + 1'b1;
            end
            // k1+k2 left shifts of the result
            if (ctl.ld_cnt_sh) begin
                res_cnt <= SH_MAX - n1 - n2;
            end else if (ctl.en_cnt_sh && ctl.shift_result) begin
                res_cnt <= res_cnt - 1'b1;
            end
        end
    end

endmodule

//--- lom_datapath.sv
module lom_datapath #(
    parameter int OP_W = lom_cfg_pkg::OP_W
) (
    input  logic              clk,
    input  logic              rst,
    lom_ctrl_if.dp            ctl,
    input  lom_cfg_pkg::op_t  eng_opnd,
    output lom_cfg_pkg::res_t res_data
);
    import lom_cfg_pkg::*;

    logic [OP_W-1:0] sr1, sr2;
    logic            zero1, zero2;

    // needs a shift while msb is clear and the word is nonzero
    assign ctl.end_shift1 = !sr1[OP_W-1] && (sr1 != '0);
    assign ctl.end_shift2 = !sr2[OP_W-1] && (sr2 != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            zero1 <= 1'b0;
            zero2 <= 1'b0;
        end else begin
            if (ctl.load_shift1) zero1 <= eng_opnd == '0;
            if (ctl.load_shift2) zero2 <= eng_opnd == '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.load_shift1) begin
            sr1 <= eng_opnd;
        end else if (ctl.en_shift1) begin
            sr1 <= sr1 << 1;
        end
        if (ctl.load_shift2) begin
            sr2 <= eng_opnd;
        end else if (ctl.en_shift2) begin
            sr2 <= sr2 << 1;
        end
        // zero operand gives a zero product
        if (ctl.load_result) begin
            res_data <= (zero1 || zero2) ? '0 : RES_W'(1);
        end else if (ctl.shift_result) begin
            res_data <= res_data << 1;
        end
    end

endmodule

//--- lom_top.sv
module lom_top #(
    parameter int OP_W      = lom_cfg_pkg::OP_W,
    parameter int MAX_PAIRS = lom_cfg_pkg::MAX_PAIRS
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [lom_regs_pkg::AXI_AW-1:0] s_awaddr,
    input  logic                             s_awvalid,
    output logic                             s_awready,
    input  logic [31:0]                      s_wdata,
    input  logic [3:0]                       s_wstrb,
    input  logic                             s_wvalid,
    output logic                             s_wready,
    output logic [1:0]                       s_bresp,
    output logic                             s_bvalid,
    input  logic                             s_bready,
    input  logic [lom_regs_pkg::AXI_AW-1:0] s_araddr,
    input  logic                             s_arvalid,
    output logic                             s_arready,
    output logic [31:0]                      s_rdata,
    output logic [1:0]                       s_rresp,
    output logic                             s_rvalid,
    input  logic                             s_rready
);
    import lom_cfg_pkg::*;

    localparam int HA_W = $clog2(2 * MAX_PAIRS) + 1;
    localparam int CW   = $clog2(MAX_PAIRS + 1);
    localparam int RI_W = $clog2(MAX_PAIRS);

    logic            start, done, host_we;
    logic [CW-1:0]   pair_count;
    logic [HA_W-1:0] host_addr;
    logic [HA_W-2:0] eng_addr;
    logic [RI_W-1:0] res_idx;
    op_t             host_wdata, eng_opnd;
    res_t            host_rdata, res_data;

    lom_ctrl_if i_ctl ();

    lom_axil_regs #(.MAX_PAIRS(MAX_PAIRS)) i_regs (
        .clk, .rst,
        .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
        .s_bresp, .s_bvalid, .s_bready, .s_araddr, .s_arvalid, .s_arready,
        .s_rdata, .s_rresp, .s_rvalid, .s_rready,
        .start, .pair_count, .host_we, .host_addr, .host_wdata, .host_rdata, .done
    );

    lom_buffers #(.MAX_PAIRS(MAX_PAIRS)) i_buf (
        .clk, .we(host_we), .addr(host_addr), .wdata(host_wdata), .rdata(host_rdata),
        .eng_addr, .eng_opnd, .res_we(i_ctl.wr_ram), .res_idx, .res_data
    );

    lom_controller i_ctrl (
        .clk, .rst, .start, .ctl(i_ctl.ctrl), .done
    );

    lom_counters #(.OP_W(OP_W), .MAX_PAIRS(MAX_PAIRS)) i_cnt (
        .clk, .rst, .ctl(i_ctl.cnt), .pair_count, .eng_addr, .res_idx
    );

    lom_datapath #(.OP_W(OP_W)) i_dp (
        .clk, .rst, .ctl(i_ctl.dp), .eng_opnd, .res_data
    );

endmodule

//--- lom_checker.sv
module lom_checker (
    input logic       clk,
    input logic       rst,
    input logic       load_shift1,
    input logic       load_shift2,
    input logic       wr_ram,
    input logic       done,
    input logic [6:0] strobes
);
    timeunit 1ns;
    timeprecision 1ps;

    // only one shift register takes the read port at a time
    a_one_load: assert property (@(posedge clk) disable iff (rst)
        !(load_shift1 && load_shift2))
        else $error("load_shift1 and load_shift2 high together");

    a_done_not_wr: assert property (@(posedge clk) disable iff (rst)
        !(done && wr_ram))
        else $error("done high together with wr_ram");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done held for more than one cycle");

    // init strobes are left out, idle drives them
    a_quiet_in_reset: assert property (@(posedge clk)
        rst |-> !(load_shift1 || load_shift2 || wr_ram || done || (|strobes)))
        else $error("controller strobe high during reset");

endmodule

bind lom_controller lom_checker i_chk (
    .clk,
    .rst,
    .load_shift1(ctl.load_shift1),
    .load_shift2(ctl.load_shift2),
    .wr_ram(ctl.wr_ram),
    .done,
    .strobes({ctl.en_cnt_load, ctl.en_shift1, ctl.en_shift2, ctl.ld_cnt_sh,
              ctl.en_cnt_sh, ctl.load_result, ctl.shift_result})
);

//--- tb_lom.sv
module tb_lom;
    timeunit 1ns;
    timeprecision 1ps;

    import lom_cfg_pkg::*;
    import lom_regs_pkg::*;

    localparam int TMO      = 200;
    localparam int POLL_MAX = 300;

    logic              clk = 1'b0;
    logic              rst;
    logic [AXI_AW-1:0] s_awaddr, s_araddr;
    logic [31:0]       s_wdata, s_rdata;
    logic [3:0]        s_wstrb;
    logic [1:0]        s_bresp, s_rresp;
    logic              s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic              s_arvalid, s_arready, s_rvalid, s_rready;

    op_t         op_a [MAX_PAIRS];
    op_t         op_b [MAX_PAIRS];
    op_t         qa [$];
    op_t         qb [$];
    int          qidx [$];
    logic [31:0] qgot [$];
    logic [31:0] last_status;
    int          seed = 32'h080f405f;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          errors_at_start = 0;
    event        results_ready;

    lom_top i_dut (.*);

    always #20 clk = ~clk;

    // product of the leading-one powers of two
    function automatic logic [31:0] lom_ref(input op_t a, input op_t b);
        int ka;
        int kb;
        if (a == 0 || b == 0) begin
            return 32'd0;
        end
        ka = 0;
        kb = 0;
        for (int i = 0; i < OP_W; i++) begin
            if (a[i]) ka = i;
            if (b[i]) kb = i;
        end
        return 32'd1 << (ka + kb);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t %s got 0x%0h exp 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int   n;
        logic accepted;
        @(negedge clk);
        s_awaddr  = addr;
        s_wdata   = data;
        s_wstrb   = 4'hf;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        n = 0;
        accepted = 1'b0;
        // both ready lines must be high at the accepting edge
        while (!accepted && n < TMO) begin
            @(posedge clk);
            accepted = s_awready && s_wready;
            n++;
        end
        @(negedge clk);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        if (!accepted) begin
            $display("timeout: write address and data never accepted for address 0x%0h", addr);
            errors++;
        end
        n = 0;
        while (!s_bvalid && n < TMO) begin
            @(negedge clk);
            n++;
        end
        resp = s_bresp;
        if (!s_bvalid) begin
            $display("timeout: no write response for address 0x%0h", addr);
            errors++;
        end
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        @(negedge clk);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        n = 0;
        while (!s_arready && n < TMO) begin
            @(negedge clk);
            n++;
        end
        // taken on the rising edge just passed
        @(negedge clk);
        s_arvalid = 1'b0;
        n = 0;
        while (!s_rvalid && n < TMO) begin
            @(negedge clk);
            n++;
        end
        data = s_rdata;
        resp = s_rresp;
        if (!s_rvalid) begin
            $display("timeout: no read data for address 0x%0h", addr);
            errors++;
        end
    endtask

    task automatic wait_done(output logic [31:0] status);
        logic [1:0] resp;
        int         polls;
        polls  = 0;
        status = '0;
        while (!status[STATUS_DONE] && polls < POLL_MAX) begin
            axi_read(REG_STATUS, status, resp);
            polls++;
        end
        if (!status[STATUS_DONE]) begin
            $display("timeout: the done bit never came up in STATUS");
            errors++;
        end
    endtask

    // operands from op_a and op_b, results go to the compare process
    task automatic load_and_run(input int n);
        logic [1:0]  resp;
        logic [31:0] rdata;
        int          waits;
        axi_write(REG_COUNT, 32'(n), resp);
        check_value("bresp COUNT", 32'(resp), 32'(RESP_OKAY));
        for (int i = 0; i < n; i++) begin
            axi_write(AXI_AW'(OPND_BASE + 8 * i), 32'(op_a[i]), resp);
            check_value("bresp operand", 32'(resp), 32'(RESP_OKAY));
            axi_write(AXI_AW'(OPND_BASE + 8 * i + 4), 32'(op_b[i]), resp);
            check_value("bresp operand", 32'(resp), 32'(RESP_OKAY));
        end
        axi_write(REG_CTRL, 32'd1, resp);
        wait_done(last_status);
        for (int j = 0; j < n; j++) begin
            axi_read(AXI_AW'(RES_BASE + 4 * j), rdata, resp);
            check_value("rresp result", 32'(resp), 32'(RESP_OKAY));
            qa.push_back(op_a[j]);
            qb.push_back(op_b[j]);
            qidx.push_back(j);
            qgot.push_back(rdata);
        end
        -> results_ready;
        waits = 0;
        while (qgot.size() != 0 && waits < TMO) begin
            @(negedge clk);
            waits++;
        end
        if (qgot.size() != 0) begin
            $display("timeout: results were never compared");
            errors++;
        end
    endtask

    task automatic begin_test();
        tests++;
        errors_at_start = errors;
    endtask

    task automatic report_test(input string name);
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - errors_at_start);
        end
    endtask

    always @(results_ready) begin : compare_results
        op_t         a;
        op_t         b;
        int          idx;
        logic [31:0] got;
        logic [31:0] exp;
        while (qgot.size() > 0) begin
            a   = qa.pop_front();
            b   = qb.pop_front();
            idx = qidx.pop_front();
            got = qgot.pop_front();
            exp = lom_ref(a, b);
            checks++;
            if (got !== exp) begin
                $display("ERR %0t result[%0d] got 0x%0h exp 0x%0h", $time, idx, got, exp);
                errors++;
            end
        end
    end

    initial begin : stimulus
        logic [1:0]  resp;
        logic [31:0] rdata;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b1;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b1;
        rst       = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        begin_test();
        op_a[0] = 8'h05;
        op_b[0] = 8'h30;
        load_and_run(1);
        check_value("STATUS", last_status, 32'h1);
        report_test("single pair");

        begin_test();
        op_a[0] = 8'h00;
        op_b[0] = 8'h40;
        op_a[1] = 8'h22;
        op_b[1] = 8'h00;
        op_a[2] = 8'h11;
        op_b[2] = 8'h09;
        load_and_run(3);
        report_test("zero operands");

        begin_test();
        for (int i = 0; i < MAX_PAIRS; i++) begin
            op_a[i] = op_t'($random(seed));
            op_b[i] = op_t'($random(seed));
        end
        load_and_run(MAX_PAIRS);
        report_test("random pairs");

        begin_test();
        op_a[0] = 8'hff;
        op_b[0] = 8'h80;
        op_a[1] = 8'h01;
        op_b[1] = 8'h01;
        load_and_run(2);
        report_test("msb and lsb operands");

        begin_test();
        axi_write(8'h20, 32'd1, resp);
        check_value("bresp unmapped", 32'(resp), 32'(RESP_SLVERR));
        axi_write(REG_COUNT, 32'd0, resp);
        check_value("bresp COUNT=0", 32'(resp), 32'(RESP_SLVERR));
        axi_read(REG_COUNT, rdata, resp);
        check_value("COUNT", rdata, 32'd2);
        axi_write(REG_CTRL, 32'd1, resp);
        axi_write(OPND_BASE, 32'h5a, resp);
        check_value("bresp operand while busy", 32'(resp), 32'(RESP_SLVERR));
        wait_done(last_status);
        axi_read(OPND_BASE, rdata, resp);
        check_value("operand 0", rdata, 32'(op_a[0]));
        report_test("error responses");

        begin_test();
        load_and_run(2);
        check_value("STATUS first read", last_status, 32'h1);
        axi_read(REG_STATUS, rdata, resp);
        check_value("STATUS second read", rdata, 32'h0);
        report_test("done clear on read");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
lom_cfg_pkg.sv
lom_regs_pkg.sv
lom_ctrl_if.sv
lom_axil_regs.sv
lom_buffers.sv
lom_controller.sv
lom_counters.sv
lom_datapath.sv
lom_top.sv
lom_checker.sv
tb_lom.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps --top-module tb_lom -f project.f \
    && ./obj_dir/Vtb_lom | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
